/* Makefile */
# Verilator build and run for the iterative divider testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = int_div_tb
FILELIST  = project.f
BUILD_DIR = obj_dir
PASS_MSG  = PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/div_testdata.txt */
# columns: fn (0 unsigned, 1 signed), dividend, divisor, expected {rem, quot}
# all fields hex, one vector per line
# unsigned
0 00000064 00000007 000000020000000E
0 00000005 00000009 0000000500000000
0 DEADBEEF 00000001 00000000DEADBEEF
0 FFFFFFFF 00000010 0000000F0FFFFFFF
0 80000000 00000003 000000022AAAAAAA
0 FFFFFFFF FFFFFFFF 0000000000000001
0 12345678 00000000 12345678FFFFFFFF
# signed, all four sign combinations
1 00000064 00000007 000000020000000E
1 FFFFFF9C 00000007 FFFFFFFEFFFFFFF2
1 00000064 FFFFFFF9 00000002FFFFFFF2
1 FFFFFF9C FFFFFFF9 FFFFFFFE0000000E
1 FFFFFFF9 00000002 FFFFFFFFFFFFFFFD
1 80000000 00000002 00000000C0000000
1 00000000 FFFFFFFD 0000000000000000
# signed corners, most negative by minus one and divide by zero
1 80000000 FFFFFFFF 0000000080000000
1 FFFFFFFB 00000000 FFFFFFFB00000001
1 00000007 00000000 00000007FFFFFFFF

/* bench/int_div_chk.sv */
//------------------------------------------------
// handshake and result stability assertions for the divider
// bound into int_div_iterative from the testbench
//------------------------------------------------

`timescale 1ns/1ps

module int_div_chk
  import div_msg_pkg::*;
(
  input logic      clk,
  input logic      reset,
  input logic      req_rdy,
  input logic      resp_val,
  input logic      resp_rdy,
  input div_resp_t resp
);

  // the unit is either taking a request or offering a result, never both
  a_rdy_val_excl: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val))
    else $error("req_rdy and resp_val high in the same cycle");

  // stalled response keeps its value and its valid
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp)))
    else $error("response changed or dropped while stalled");

  // one transfer per division
  a_val_drop: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy) |=> !resp_val)
    else $error("resp_val still high after the response transfer");

endmodule

/* bench/int_div_tb.sv */
//------------------------------------------------
// testbench for the iterative divider driven by vectors from bench/div_testdata.txt
// random request gaps and response stalls with latency and hold checks per vector
//------------------------------------------------

`timescale 1ns/1ps

module int_div_tb
  import div_msg_pkg::*;
();

  logic      clk;
  logic      reset;
  div_req_t  req;
  logic      req_val;
  logic      req_rdy;
  div_resp_t resp;
  logic      resp_val;
  logic      resp_rdy;

  // vectors as read from the data file
  logic        vec_fn[$];
  logic [31:0] vec_a[$];
  logic [31:0] vec_b[$];
  logic [63:0] vec_exp[$];

  int          err_count;
  int          fail_tests;
  int          cycle_limit;
  int          cycles;
  logic [31:0] rand_state;
  bit          vectors_ok;

  int_div_iterative uut (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  bind int_div_iterative int_div_chk chk (
    .clk      (clk),
    .reset    (reset),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp     (resp)
  );

  // 10 ns period
  always #5 clk = ~clk;

  //------------------------------------------------
  // helpers
  //------------------------------------------------

  // LCG step returning the better mixed upper half
  function automatic logic [31:0] lcg_next();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return {16'h0000, rand_state[31:16]};
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      err_count++;
    end
  endtask

  task automatic load_vectors(output bit ok);
    int          fd;
    int          code;
    string       line;
    logic [31:0] f_fn;
    logic [31:0] f_a;
    logic [31:0] f_b;
    logic [63:0] f_exp;
    ok = 1'b0;
    fd = $fopen("bench/div_testdata.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        // comment and blank lines do not give four fields
        code = $sscanf(line, "%h %h %h %h", f_fn, f_a, f_b, f_exp);
        if (code == 4) begin
          vec_fn.push_back(f_fn[0]);
          vec_a.push_back(f_a);
          vec_b.push_back(f_b);
          vec_exp.push_back(f_exp);
        end
      end
      $fclose(fd);
      ok = (vec_a.size() > 0);
    end
  endtask

  //------------------------------------------------
  // one division from request to response
  //------------------------------------------------

  task automatic run_vector(input int idx);
    string     name;
    int        gap;
    int        stall;
    int        lat;
    int        errs_before;
    div_resp_t held;
    name = $sformatf("vec%0d_%s", idx, vec_fn[idx] ? "signed" : "unsigned");
    errs_before = err_count;
    gap = int'(lcg_next() % 32'd4);
    repeat (gap) @(posedge clk);
    req.fn  <= div_fn_e'(vec_fn[idx]);
    req.a   <= vec_a[idx];
    req.b   <= vec_b[idx];
    req_val <= 1'b1;
    // accepting edge is the first one that sees req_rdy high
    do begin
      @(posedge clk);
    end while (!req_rdy);
    req_val <= 1'b0;
    // edges from accept until resp_val is seen
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
      if (!resp_val) begin
        check_value({name, "_rdy_busy"}, 64'd0, 64'(req_rdy));
      end
    end while (!resp_val);
    check_value({name, "_latency"}, 64'd33, 64'(lat));
    held = resp;
    stall = int'(lcg_next() % 32'd8);
    // consumer not ready yet
    repeat (stall) begin
      @(posedge clk);
      check_value({name, "_hold"}, held, resp);
      check_value({name, "_val_hold"}, 64'd1, 64'(resp_val));
      check_value({name, "_rdy_stall"}, 64'd0, 64'(req_rdy));
    end
    resp_rdy <= 1'b1;
    @(posedge clk);
    // response transfers on this edge with valid and ready both high
    check_value({name, "_result"}, vec_exp[idx], resp);
    resp_rdy <= 1'b0;
    @(posedge clk);
    check_value({name, "_val_drop"}, 64'd0, 64'(resp_val));
    check_value({name, "_rdy_back"}, 64'd1, 64'(req_rdy));
    if (err_count == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d error(s)", name, err_count - errs_before);
      fail_tests++;
    end
  endtask

  //------------------------------------------------
  // main sequence
  //------------------------------------------------

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    req        = '0;
    req_val    = 1'b0;
    resp_rdy   = 1'b0;
    err_count  = 0;
    fail_tests = 0;
    rand_state = 32'h5728;
    load_vectors(vectors_ok);
    // reset plus about 48 cycles per vector and some slack
    cycle_limit = 16 + vec_a.size() * 48 + 100;
    if (!vectors_ok) begin
      $display("no test vectors could be read from bench/div_testdata.txt");
      $display("FAIL: see errors above");
    end else begin
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      check_value("reset_req_rdy", 64'd1, 64'(req_rdy));
      check_value("reset_resp_val", 64'd0, 64'(resp_val));
      if (err_count == 0) begin
        $display("test reset: ok");
      end else begin
        $display("test reset: %0d error(s)", err_count);
        fail_tests++;
      end
      for (int i = 0; i < vec_a.size(); i++) begin
        run_vector(i);
      end
      $display("tests run: %0d, tests failed: %0d, check errors: %0d",
               vec_a.size() + 1, fail_tests, err_count);
      if (err_count == 0) begin
        $display("PASS: all tests");
      end else begin
        $display("FAIL: see errors above");
      end
    end
    $finish;
  end

  // cycle limit guards against a stuck handshake
  initial begin
    cycles = 0;
    @(posedge clk);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the divider stopped responding", cycles);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* hdl/div_ctrl_pkg.sv */
//------------------------------------------------
// control definitions shared by the divider FSM and datapath
//------------------------------------------------

package div_ctrl_pkg;

  // one iteration per quotient bit
  localparam int DIV_STEPS   = 32;
  // wide enough to count 0 .. DIV_STEPS-1
  localparam int DIV_COUNT_W = 5;

  //------------------------------------------------
  // FSM states
  //------------------------------------------------

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } div_state_e;

  // control word from the FSM to the datapath
  typedef struct packed {
    // capture operand magnitudes and signs
    logic load;
    // one shift-subtract-restore iteration
    logic step;
  } div_ctrl_t;

endpackage

/* hdl/div_msg_pkg.sv */
//------------------------------------------------
// message formats for the iterative divider
// request carries fn and both operands, response packs {rem, quot}
//------------------------------------------------

package div_msg_pkg;

  //------------------------------------------------
  // widths
  //------------------------------------------------

  // operand width, also the width of each result half
  localparam int DIV_WIDTH = 32;

  //------------------------------------------------
  // function codes
  //------------------------------------------------

  typedef enum logic {
    DIV_UNSIGNED = 1'b0,
    DIV_SIGNED   = 1'b1
  } div_fn_e;

  //------------------------------------------------
  // request and response words
  //------------------------------------------------

  // fn in the top bit, then dividend, then divisor
  typedef struct packed {
    div_fn_e              fn;
    logic [DIV_WIDTH-1:0] a;
    logic [DIV_WIDTH-1:0] b;
  } div_req_t;

  // remainder in the upper half, quotient in the lower half
  typedef struct packed {
    logic [DIV_WIDTH-1:0] rem;
    logic [DIV_WIDTH-1:0] quot;
  } div_resp_t;

endpackage

/* hdl/int_div_ctrl.sv */
//------------------------------------------------
// divider control unit
// three-state FSM, iteration counter and val/rdy handshake decode
//------------------------------------------------

`timescale 1ns/1ps

module int_div_ctrl
  import div_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  // request side handshake
  input  logic      req_val,
  output logic      req_rdy,

  // response side handshake
  output logic      resp_val,
  input  logic      resp_rdy,

  // control word to the datapath
  output div_ctrl_t ctrl
);

  div_state_e             state;
  logic [DIV_COUNT_W-1:0] count;

  logic req_fire;
  logic resp_fire;
  logic last_step;

  // transfers on either channel
  assign req_fire  = req_val && req_rdy;
  assign resp_fire = resp_val && resp_rdy;

  // counter sits at DIV_STEPS-1 during the final iteration
  assign last_step = (count == DIV_COUNT_W'(DIV_STEPS - 1));

  //------------------------------------------------
  // state and counter
  //------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      count <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          // accepting edge, datapath loads on this same edge
          if (req_fire) begin
            state <= ST_CALC;
            count <= '0;
          end
        end

        ST_CALC: begin
          // step is high every CALC cycle, counter tracks how many done
          count <= count + 1'b1;
          if (last_step) begin
            state <= ST_DONE;
          end
        end

        ST_DONE: begin
          // result held until the consumer takes it
          if (resp_fire) begin
            state <= ST_IDLE;
          end
        end

        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  //------------------------------------------------
  // output decode
  //------------------------------------------------

  always_comb begin
    req_rdy   = (state == ST_IDLE);
    resp_val  = (state == ST_DONE);
    // load only when a request is really being taken
    ctrl.load = (state == ST_IDLE) && req_val;
    // 32 CALC cycles, resp_val is first sampled high on the 33rd edge
    ctrl.step = (state == ST_CALC);
  end

endmodule

/* hdl/int_div_dpath.sv */
//------------------------------------------------
// divider datapath
// restoring shift-subtract core with signed magnitude conversion
//------------------------------------------------

`timescale 1ns/1ps

module int_div_dpath
  import div_msg_pkg::*, div_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  // operands sampled when ctrl.load is high
  input  div_req_t  req,

  // control word from the FSM
  input  div_ctrl_t ctrl,

  // {rem, quot} valid throughout ST_DONE
  output div_resp_t resp
);

  // two's complement negate when neg is set
  function automatic logic [DIV_WIDTH-1:0] cond_neg(
    input logic                 neg,
    input logic [DIV_WIDTH-1:0] val
  );
    cond_neg = neg ? (~val + 1'b1) : val;
  endfunction

  //------------------------------------------------
  // operand magnitudes
  //------------------------------------------------

  logic                 is_signed;
  logic                 a_neg;
  logic                 b_neg;
  logic [DIV_WIDTH-1:0] a_mag;
  logic [DIV_WIDTH-1:0] b_mag;

  // unsigned mode leaves both sign flags clear
  assign is_signed = (req.fn == DIV_SIGNED);
  assign a_neg     = is_signed && req.a[DIV_WIDTH-1];
  assign b_neg     = is_signed && req.b[DIV_WIDTH-1];

  assign a_mag = cond_neg(a_neg, req.a);
  assign b_mag = cond_neg(b_neg, req.b);

  //------------------------------------------------
  // shift-subtract-restore step
  //------------------------------------------------

  // rq_reg holds the partial remainder above and the quotient bits shifting in below
  logic [2*DIV_WIDTH:0] rq_reg;
  // divisor magnitude lined up with the upper word under a zero guard bit
  logic [2*DIV_WIDTH:0] div_reg;
  logic                 quot_neg_reg;
  logic                 rem_neg_reg;

  logic [2*DIV_WIDTH:0] rq_shift;
  logic [2*DIV_WIDTH:0] rq_diff;
  logic [2*DIV_WIDTH:0] rq_step;
  logic                 diff_neg;

  assign rq_shift = rq_reg << 1;
  assign rq_diff  = rq_shift - div_reg;
  // guard bit set means the divisor did not fit
  assign diff_neg = rq_diff[2*DIV_WIDTH];

  // low bit of the shifted word is free for the new quotient bit
  always_comb begin
    if (diff_neg) begin
      rq_step = {rq_shift[2*DIV_WIDTH:1], 1'b0};
    end else begin
      rq_step = {rq_diff[2*DIV_WIDTH:1], 1'b1};
    end
  end

  //------------------------------------------------
  // registers
  //------------------------------------------------

  // remainder/quotient register and sign flags
  always_ff @(posedge clk) begin
    if (reset) begin
      rq_reg       <= '0;
      quot_neg_reg <= 1'b0;
      rem_neg_reg  <= 1'b0;
    end else if (ctrl.load) begin
      // dividend magnitude enters at the bottom
      rq_reg       <= {1'b0, {DIV_WIDTH{1'b0}}, a_mag};
      // quotient negative when signs differ
      quot_neg_reg <= a_neg ^ b_neg;
      // remainder follows the dividend
      rem_neg_reg  <= a_neg;
    end else if (ctrl.step) begin
      rq_reg <= rq_step;
    end
  end

  // divisor only changes on load
  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      div_reg <= {1'b0, b_mag, {DIV_WIDTH{1'b0}}};
    end
  end

  //------------------------------------------------
  // sign fix-up
  //------------------------------------------------

  logic [DIV_WIDTH-1:0] quot_mag;
  logic [DIV_WIDTH-1:0] rem_mag;

  // after DIV_STEPS iterations the guard bit is zero again
  assign quot_mag = rq_reg[DIV_WIDTH-1:0];
  assign rem_mag  = rq_reg[2*DIV_WIDTH-1:DIV_WIDTH];

  // divide by zero arrives here with an all-ones quotient and the dividend as remainder
  assign resp.quot = cond_neg(quot_neg_reg, quot_mag);
  assign resp.rem  = cond_neg(rem_neg_reg, rem_mag);

endmodule

/* hdl/int_div_iterative.sv */
//------------------------------------------------
// iterative 32-bit integer divider, top level
// val/rdy request in, {rem, quot} response out, one division at a time
//------------------------------------------------

`timescale 1ns/1ps

module int_div_iterative
  import div_msg_pkg::*, div_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  // request channel
  input  div_req_t  req,
  input  logic      req_val,
  output logic      req_rdy,

  // response channel
  output div_resp_t resp,
  output logic      resp_val,
  input  logic      resp_rdy
);

  // load and step from the FSM, nothing comes back
  div_ctrl_t ctrl_word;

  int_div_ctrl ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .ctrl     (ctrl_word)
  );

  // restore decision stays inside the datapath
  int_div_dpath dpath (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .ctrl  (ctrl_word),
    .resp  (resp)
  );

endmodule

/* project.f */
hdl/div_msg_pkg.sv
hdl/div_ctrl_pkg.sv
hdl/int_div_ctrl.sv
hdl/int_div_dpath.sv
hdl/int_div_iterative.sv
bench/int_div_chk.sv
bench/int_div_tb.sv
